//--- bpu_pkg.sv
// Codes and table sizes for the predictor. Table addresses are 30-bit word addresses
package bpu_pkg;

	// ------------------------------
	// Decoder control-flow kind
	// ------------------------------
	localparam logic [1:0] INVALID   = 2'd0;
	localparam logic [1:0] CONDITION = 2'd1;
	localparam logic [1:0] IMMEDIATE = 2'd2;
	localparam logic [1:0] INDIRECT  = 2'd3;

	// Compare op for conditional branches
	localparam logic [2:0] EQL = 3'd0;
	localparam logic [2:0] NEQ = 3'd1;
	localparam logic [2:0] LSS = 3'd2;
	localparam logic [2:0] GER = 3'd3;
	localparam logic [2:0] LEQ = 3'd4;
	localparam logic [2:0] GEQ = 3'd5;
	localparam logic [2:0] LTU = 3'd6;
	localparam logic [2:0] GEU = 3'd7;

	// ------------------------------
	// Branch class kept in the BTB
	// ------------------------------
	typedef logic [1:0] br_class;

	localparam br_class CALL        = 2'd0;
	localparam br_class RETURN      = 2'd1;
	localparam br_class ABSOLUTE    = 2'd2;
	localparam br_class PC_RELATIVE = 2'd3;

	// ------------------------------
	// Table geometry
	// ------------------------------
	localparam int BTB_ENTRIES = 16;
	localparam int BTB_IDX_W   = 4;
	localparam int BTB_TAG_W   = 8;

	localparam int BHT_ENTRIES = 64;
	localparam int BHT_IDX_W   = 6;

	localparam int RAS_DEPTH = 4;
	localparam int RAS_PTR_W = 2;

	// Weakly not taken
	localparam logic [1:0] BHT_INIT = 2'b01;

	// Instruction bits [25:0], read as a long offset or as offs16/rj/rd
	typedef union packed {
		struct packed {
			logic [15:0] offs_hi;
			logic [9:0]  offs_lo;
		} offs;
		struct packed {
			logic [15:0] offs16;
			logic [4:0]  rj;
			logic [4:0]  rd;
		} regs;
	} inst_field_u;

endpackage

//--- bpu_btb.sv
// Direct mapped with no associativity. Only taken branches should be written and a conflict evicts
`timescale 1ns/1ps

module bpu_btb (
	input  logic             clk,
	input  logic             arst_n_i,
	input  logic [29:0]      rd_pc_i,
	output logic             hit_o,
	output logic [29:0]      target_o,
	output bpu_pkg::br_class class_o,
	input  logic             wr_en_i,
	input  logic [29:0]      wr_pc_i,
	input  logic [29:0]      wr_target_i,
	input  bpu_pkg::br_class wr_class_i
);

	logic [bpu_pkg::BTB_ENTRIES-1:0] valid_q;
	logic [bpu_pkg::BTB_TAG_W-1:0]   tag_q    [bpu_pkg::BTB_ENTRIES];
	logic [29:0]                     target_q [bpu_pkg::BTB_ENTRIES];
	bpu_pkg::br_class                class_q  [bpu_pkg::BTB_ENTRIES];

	logic [bpu_pkg::BTB_IDX_W-1:0] rd_idx;
	logic [bpu_pkg::BTB_IDX_W-1:0] wr_idx;
	logic [bpu_pkg::BTB_TAG_W-1:0] rd_tag;
	logic [bpu_pkg::BTB_TAG_W-1:0] wr_tag;

	// Word address bits [3:0] are pc[5:2], tag is pc[13:6]
	assign rd_idx = rd_pc_i[bpu_pkg::BTB_IDX_W-1:0];
	assign rd_tag = rd_pc_i[bpu_pkg::BTB_IDX_W +: bpu_pkg::BTB_TAG_W];
	assign wr_idx = wr_pc_i[bpu_pkg::BTB_IDX_W-1:0];
	assign wr_tag = wr_pc_i[bpu_pkg::BTB_IDX_W +: bpu_pkg::BTB_TAG_W];

	assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
	assign target_o = target_q[rd_idx];
	assign class_o  = class_q[rd_idx];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= '0;
		end else if (wr_en_i) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	// Entry payload
	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			tag_q[wr_idx]    <= wr_tag;
			target_q[wr_idx] <= wr_target_i;
			class_q[wr_idx]  <= wr_class_i;
		end
	end

	a_wr_pc_known: assert property (@(posedge clk) disable iff (!arst_n_i)
		wr_en_i |-> !$isunknown(wr_pc_i))
		else $error("btb write with unknown pc");

endmodule

//--- bpu_bht.sv
// Direction only and no history. Aliasing between branches that share pc[7:2] is expected
`timescale 1ns/1ps

module bpu_bht (
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic [29:0] rd_pc_i,
	output logic        taken_o,
	input  logic        wr_en_i,
	input  logic [29:0] wr_pc_i,
	input  logic        wr_taken_i
);

	logic [1:0] cnt_q [bpu_pkg::BHT_ENTRIES];

	logic [bpu_pkg::BHT_IDX_W-1:0] rd_idx;
	logic [bpu_pkg::BHT_IDX_W-1:0] wr_idx;

	assign rd_idx = rd_pc_i[bpu_pkg::BHT_IDX_W-1:0];
	assign wr_idx = wr_pc_i[bpu_pkg::BHT_IDX_W-1:0];

	// Upper bit of the counter is the prediction
	assign taken_o = cnt_q[rd_idx][1];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < bpu_pkg::BHT_ENTRIES; i++) begin
				cnt_q[i] <= bpu_pkg::BHT_INIT;
			end
		end else if (wr_en_i) begin
			// Saturate at 3 and 0
			if (wr_taken_i && cnt_q[wr_idx] != 2'b11) begin
				cnt_q[wr_idx] <= cnt_q[wr_idx] + 2'd1;
			end else if (!wr_taken_i && cnt_q[wr_idx] != 2'b00) begin
				cnt_q[wr_idx] <= cnt_q[wr_idx] - 2'd1;
			end
		end
	end

endmodule

//--- bpu_ras.sv
// Trained at resolve only with no speculative repair. Overflow drops the oldest return address
`timescale 1ns/1ps

module bpu_ras (
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic        push_i,
	input  logic [29:0] push_addr_i,
	input  logic        pop_i,
	output logic [29:0] top_o,
	output logic        empty_o
);

	logic [29:0] stack_q [bpu_pkg::RAS_DEPTH];

	// Pointer to the next free slot
	logic [bpu_pkg::RAS_PTR_W-1:0] ptr_q;
	logic [bpu_pkg::RAS_PTR_W:0]   cnt_q;
	logic [bpu_pkg::RAS_PTR_W-1:0] top_ptr;

	assign top_ptr = ptr_q - (bpu_pkg::RAS_PTR_W)'(1);
	assign top_o   = stack_q[top_ptr];
	assign empty_o = (cnt_q == '0);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ptr_q <= '0;
			cnt_q <= '0;
		end else if (push_i) begin
			ptr_q <= ptr_q + (bpu_pkg::RAS_PTR_W)'(1);
			if (cnt_q != (bpu_pkg::RAS_PTR_W + 1)'(bpu_pkg::RAS_DEPTH)) begin
				cnt_q <= cnt_q + (bpu_pkg::RAS_PTR_W + 1)'(1);
			end
		end else if (pop_i && !empty_o) begin
			ptr_q <= top_ptr;
			cnt_q <= cnt_q - (bpu_pkg::RAS_PTR_W + 1)'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (push_i) begin
			stack_q[ptr_q] <= push_addr_i;
		end
	end

	// One resolved branch per cycle, a call and a return never coincide
	a_no_push_pop: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(push_i && pop_i))
		else $error("ras push and pop in the same cycle");

endmodule

//--- bpu_predictor.sv
// Lookup is combinational in the fetch cycle. Training lands one edge after a valid resolve
`timescale 1ns/1ps

module bpu_predictor (
	input  logic             clk,
	input  logic             arst_n_i,
	input  logic [31:0]      fetch_pc_i,
	output logic             pred_taken_o,
	output logic [29:0]      pred_npc_o,
	input  logic             upd_valid_i,
	input  logic [29:0]      upd_pc_i,
	input  logic             upd_taken_i,
	input  logic [29:0]      upd_target_i,
	input  bpu_pkg::br_class upd_class_i,
	input  logic             upd_is_cond_i
);

	logic             btb_hit;
	logic [29:0]      btb_target;
	bpu_pkg::br_class btb_class;
	logic             bht_taken;
	logic [29:0]      ras_top;
	logic             ras_empty;

	logic        btb_wr;
	logic        bht_wr;
	logic        ras_push;
	logic        ras_pop;
	logic [29:0] fall_npc;
	logic [29:0] hit_npc;

	// ------------------------------
	// Fetch lookup
	// ------------------------------
	bpu_btb u_btb (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.rd_pc_i     (fetch_pc_i[31:2]),
		.hit_o       (btb_hit),
		.target_o    (btb_target),
		.class_o     (btb_class),
		.wr_en_i     (btb_wr),
		.wr_pc_i     (upd_pc_i),
		.wr_target_i (upd_target_i),
		.wr_class_i  (upd_class_i)
	);

	bpu_bht u_bht (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.rd_pc_i    (fetch_pc_i[31:2]),
		.taken_o    (bht_taken),
		.wr_en_i    (bht_wr),
		.wr_pc_i    (upd_pc_i),
		.wr_taken_i (upd_taken_i)
	);

	bpu_ras u_ras (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.push_i      (ras_push),
		.push_addr_i (upd_pc_i + 30'd1),
		.pop_i       (ras_pop),
		.top_o       (ras_top),
		.empty_o     (ras_empty)
	);

	// Next aligned 8-byte group as a word address
	assign fall_npc = {fetch_pc_i[31:3] + 29'd1, 1'b0};

	// Empty stack falls back to the BTB target
	assign hit_npc = (btb_class == bpu_pkg::RETURN && !ras_empty) ? ras_top : btb_target;

	// Unconditional classes go taken on a hit, PC-relative asks the BHT
	assign pred_taken_o = btb_hit && (btb_class != bpu_pkg::PC_RELATIVE || bht_taken);
	assign pred_npc_o   = pred_taken_o ? hit_npc : fall_npc;

	// ------------------------------
	// Training
	// ------------------------------
	assign btb_wr   = upd_valid_i && upd_taken_i;
	assign bht_wr   = upd_valid_i && upd_is_cond_i;
	assign ras_push = btb_wr && (upd_class_i == bpu_pkg::CALL);
	assign ras_pop  = btb_wr && (upd_class_i == bpu_pkg::RETURN);

endmodule

//--- bpf.sv
// Purely combinational resolve. stall_i masks training and the mispredict flush but not csr_flush_i
`timescale 1ns/1ps

module bpf (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 res_valid_i,
	input  logic                 stall_i,
	input  logic                 csr_flush_i,
	input  logic [31:0]          csr_target_i,
	input  logic [31:0]          pc_i,
	input  logic [31:0]          rj_i,
	input  logic [31:0]          rd_i,
	input  bpu_pkg::inst_field_u inst_i,
	input  logic [1:0]           branch_type_i,
	input  logic [2:0]           cmp_type_i,
	input  logic                 branch_link_i,
	input  logic                 pred_taken_i,
	input  logic [29:0]          pred_npc_i,
	output logic                 flush_o,
	output logic [31:0]          redirect_pc_o,
	output logic                 br_taken_o,
	output bpu_pkg::br_class     br_class_o,
	output logic [31:0]          pc_link_o,
	output logic                 upd_valid_o,
	output logic [29:0]          upd_pc_o,
	output logic [29:0]          upd_target_o,
	output logic                 upd_is_cond_o
);

	logic        taken;
	logic [31:0] offs26;
	logic [31:0] offs16;
	logic [31:0] fall_pc;
	logic [31:0] target;
	logic        dir_miss;
	logic        tgt_miss;

	// Long offset keeps its sign in offs_lo
	assign offs26  = {{4{inst_i.offs.offs_lo[9]}}, inst_i.offs.offs_lo, inst_i.offs.offs_hi, 2'b00};
	assign offs16  = {{14{inst_i.regs.offs16[15]}}, inst_i.regs.offs16, 2'b00};
	assign fall_pc = {pc_i[31:3] + 29'd1, 3'b000};

	// ------------------------------
	// Direction and target
	// ------------------------------
	always_comb begin
		taken = 1'b0;
		if (branch_type_i == bpu_pkg::CONDITION) begin
			case (cmp_type_i)
				bpu_pkg::EQL: taken = (rj_i == rd_i);
				bpu_pkg::NEQ: taken = (rj_i != rd_i);
				bpu_pkg::LSS: taken = ($signed(rj_i) < $signed(rd_i));
				bpu_pkg::GER: taken = ($signed(rj_i) > $signed(rd_i));
				bpu_pkg::LEQ: taken = ($signed(rj_i) <= $signed(rd_i));
				bpu_pkg::GEQ: taken = ($signed(rj_i) >= $signed(rd_i));
				bpu_pkg::LTU: taken = (rj_i < rd_i);
				bpu_pkg::GEU: taken = (rj_i >= rd_i);
			endcase
		end else if (branch_type_i != bpu_pkg::INVALID) begin
			taken = 1'b1;
		end
	end

	always_comb begin
		case (branch_type_i)
			bpu_pkg::IMMEDIATE: target = pc_i + offs26;
			bpu_pkg::INDIRECT:  target = rj_i + offs16;
			bpu_pkg::CONDITION: target = taken ? pc_i + offs16 : fall_pc;
			default:            target = fall_pc;
		endcase
	end

	assign br_taken_o = taken;
	assign pc_link_o  = pc_i + 32'd4;

	// ------------------------------
	// Mispredict and redirect
	// ------------------------------
	assign dir_miss = (pred_taken_i != taken);
	assign tgt_miss = ({pred_npc_i, 2'b00} != target);
	assign flush_o  = (res_valid_i && !stall_i && (dir_miss || (tgt_miss && pred_taken_i)))
		|| csr_flush_i;

	// First slot of a group predicted taken but falling through resumes at the second slot
	always_comb begin
		if (csr_flush_i) begin
			redirect_pc_o = csr_target_i;
		end else if (!pc_i[2] && pred_taken_i && !taken) begin
			redirect_pc_o = pc_link_o;
		end else begin
			redirect_pc_o = target;
		end
	end

	always_comb begin
		if ((branch_type_i == bpu_pkg::INDIRECT && inst_i.regs.rd == 5'd1) || branch_link_i) begin
			br_class_o = bpu_pkg::CALL;
		end else if (branch_type_i == bpu_pkg::INDIRECT && inst_i.regs.rj == 5'd1
				&& inst_i.regs.offs16 == '0) begin
			br_class_o = bpu_pkg::RETURN;
		end else if (branch_type_i == bpu_pkg::IMMEDIATE || branch_type_i == bpu_pkg::INDIRECT) begin
			br_class_o = bpu_pkg::ABSOLUTE;
		end else begin
			br_class_o = bpu_pkg::PC_RELATIVE;
		end
	end

	// Training goes out as word addresses
	assign upd_valid_o   = res_valid_i && !stall_i;
	assign upd_pc_o      = pc_i[31:2];
	assign upd_target_o  = target[31:2];
	assign upd_is_cond_o = (branch_type_i == bpu_pkg::CONDITION);

	a_decode_known: assert property (@(posedge clk) disable iff (!arst_n_i)
		res_valid_i |-> !$isunknown({branch_type_i, cmp_type_i, branch_link_i}))
		else $error("resolve with unknown decode fields");

endmodule

//--- bpu_top.sv
// Fetch and resolve run in the same cycle. Pipeline must carry pred_taken_o and pred_npc_o to resolve
`timescale 1ns/1ps

module bpu_top (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic [31:0]          fetch_pc_i,
	output logic                 pred_taken_o,
	output logic [29:0]          pred_npc_o,
	input  logic                 res_valid_i,
	input  logic                 stall_i,
	input  logic                 csr_flush_i,
	input  logic [31:0]          csr_target_i,
	input  logic [31:0]          res_pc_i,
	input  logic [31:0]          rj_val_i,
	input  logic [31:0]          rd_val_i,
	input  bpu_pkg::inst_field_u inst_i,
	input  logic [1:0]           branch_type_i,
	input  logic [2:0]           cmp_type_i,
	input  logic                 branch_link_i,
	input  logic                 res_pred_taken_i,
	input  logic [29:0]          res_pred_npc_i,
	output logic                 flush_o,
	output logic [31:0]          redirect_pc_o,
	output logic                 br_taken_o,
	output bpu_pkg::br_class     br_class_o,
	output logic [31:0]          pc_link_o
);

	logic        upd_valid;
	logic [29:0] upd_pc;
	logic [29:0] upd_target;
	logic        upd_is_cond;

	bpu_predictor u_predictor (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.fetch_pc_i    (fetch_pc_i),
		.pred_taken_o  (pred_taken_o),
		.pred_npc_o    (pred_npc_o),
		.upd_valid_i   (upd_valid),
		.upd_pc_i      (upd_pc),
		.upd_taken_i   (br_taken_o),
		.upd_target_i  (upd_target),
		.upd_class_i   (br_class_o),
		.upd_is_cond_i (upd_is_cond)
	);

	bpf u_bpf (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.res_valid_i   (res_valid_i),
		.stall_i       (stall_i),
		.csr_flush_i   (csr_flush_i),
		.csr_target_i  (csr_target_i),
		.pc_i          (res_pc_i),
		.rj_i          (rj_val_i),
		.rd_i          (rd_val_i),
		.inst_i        (inst_i),
		.branch_type_i (branch_type_i),
		.cmp_type_i    (cmp_type_i),
		.branch_link_i (branch_link_i),
		.pred_taken_i  (res_pred_taken_i),
		.pred_npc_i    (res_pred_npc_i),
		.flush_o       (flush_o),
		.redirect_pc_o (redirect_pc_o),
		.br_taken_o    (br_taken_o),
		.br_class_o    (br_class_o),
		.pc_link_o     (pc_link_o),
		.upd_valid_o   (upd_valid),
		.upd_pc_o      (upd_pc),
		.upd_target_o  (upd_target),
		.upd_is_cond_o (upd_is_cond)
	);

endmodule

//--- tb_bpu.sv
// Drives bpu_top with random and directed branches. Resolve checks use ref_resolve and lookups use fixed word addresses
`timescale 1ns/1ps

module tb_bpu;

	// Resolve cycles in all test groups, with room for the resets
	localparam int N_CYCLES = 340;

	logic             clk;
	logic             arst_n_i;
	logic [31:0]      fetch_pc_i;
	logic             pred_taken_o;
	logic [29:0]      pred_npc_o;
	logic             res_valid_i;
	logic             stall_i;
	logic             csr_flush_i;
	logic [31:0]      csr_target_i;
	logic [31:0]      res_pc_i;
	logic [31:0]      rj_val_i;
	logic [31:0]      rd_val_i;
	logic [25:0]      inst_bits;
	logic [1:0]       branch_type_i;
	logic [2:0]       cmp_type_i;
	logic             branch_link_i;
	logic             res_pred_taken_i;
	logic [29:0]      res_pred_npc_i;
	logic             flush_o;
	logic [31:0]      redirect_pc_o;
	logic             br_taken_o;
	bpu_pkg::br_class br_class_o;
	logic [31:0]      pc_link_o;

	logic [31:0] lfsr_q;
	int          err_cnt;

	bpu_top u_dut (
		.clk              (clk),
		.arst_n_i         (arst_n_i),
		.fetch_pc_i       (fetch_pc_i),
		.pred_taken_o     (pred_taken_o),
		.pred_npc_o       (pred_npc_o),
		.res_valid_i      (res_valid_i),
		.stall_i          (stall_i),
		.csr_flush_i      (csr_flush_i),
		.csr_target_i     (csr_target_i),
		.res_pc_i         (res_pc_i),
		.rj_val_i         (rj_val_i),
		.rd_val_i         (rd_val_i),
		.inst_i           (inst_bits),
		.branch_type_i    (branch_type_i),
		.cmp_type_i       (cmp_type_i),
		.branch_link_i    (branch_link_i),
		.res_pred_taken_i (res_pred_taken_i),
		.res_pred_npc_i   (res_pred_npc_i),
		.flush_o          (flush_o),
		.redirect_pc_o    (redirect_pc_o),
		.br_taken_o       (br_taken_o),
		.br_class_o       (br_class_o),
		.pc_link_o        (pc_link_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic fail_run(input string msg);
		err_cnt++;
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_class(input string name, input bpu_pkg::br_class got,
			input bpu_pkg::br_class exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
	endtask

	// Galois LFSR, one step per bit
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = lfsr_q[0];
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
		end
		return v;
	endfunction

	// Reference for the resolve side, from the current inputs
	function automatic void ref_resolve(output logic e_taken, output logic e_flush,
			output logic [31:0] e_redir, output bpu_pkg::br_class e_class);
		logic [31:0] off26;
		logic [31:0] off16;
		logic [31:0] fall;
		logic [31:0] tgt;
		logic        miss;
		off26 = {{4{inst_bits[9]}}, inst_bits[9:0], inst_bits[25:10], 2'b00};
		off16 = {{14{inst_bits[25]}}, inst_bits[25:10], 2'b00};
		fall  = (res_pc_i & 32'hFFFF_FFF8) + 32'd8;
		e_taken = 1'b0;
		case (branch_type_i)
			bpu_pkg::CONDITION: begin
				case (cmp_type_i)
					bpu_pkg::EQL: e_taken = rj_val_i == rd_val_i;
					bpu_pkg::NEQ: e_taken = rj_val_i != rd_val_i;
					bpu_pkg::LSS: e_taken = $signed(rj_val_i) < $signed(rd_val_i);
					bpu_pkg::GER: e_taken = $signed(rj_val_i) > $signed(rd_val_i);
					bpu_pkg::LEQ: e_taken = $signed(rj_val_i) <= $signed(rd_val_i);
					bpu_pkg::GEQ: e_taken = $signed(rj_val_i) >= $signed(rd_val_i);
					bpu_pkg::LTU: e_taken = rj_val_i < rd_val_i;
					default:      e_taken = rj_val_i >= rd_val_i;
				endcase
				tgt = e_taken ? res_pc_i + off16 : fall;
			end
			bpu_pkg::IMMEDIATE: begin
				e_taken = 1'b1;
				tgt = res_pc_i + off26;
			end
			bpu_pkg::INDIRECT: begin
				e_taken = 1'b1;
				tgt = rj_val_i + off16;
			end
			default: tgt = fall;
		endcase
		miss = (res_pred_taken_i != e_taken)
			|| (res_pred_taken_i && {res_pred_npc_i, 2'b00} != tgt);
		e_flush = (res_valid_i && !stall_i && miss) || csr_flush_i;
		if (csr_flush_i)
			e_redir = csr_target_i;
		else if (!res_pc_i[2] && res_pred_taken_i && !e_taken)
			e_redir = res_pc_i + 32'd4;
		else
			e_redir = tgt;
		if ((branch_type_i == bpu_pkg::INDIRECT && inst_bits[4:0] == 5'd1) || branch_link_i)
			e_class = bpu_pkg::CALL;
		else if (branch_type_i == bpu_pkg::INDIRECT && inst_bits[9:5] == 5'd1
				&& inst_bits[25:10] == 16'h0)
			e_class = bpu_pkg::RETURN;
		else if (branch_type_i == bpu_pkg::IMMEDIATE || branch_type_i == bpu_pkg::INDIRECT)
			e_class = bpu_pkg::ABSOLUTE;
		else
			e_class = bpu_pkg::PC_RELATIVE;
	endfunction

	// Resolve outputs are stable by the falling edge
	always @(negedge clk) begin
		logic             e_taken;
		logic             e_flush;
		logic [31:0]      e_redir;
		bpu_pkg::br_class e_class;
		if (arst_n_i) begin
			ref_resolve(e_taken, e_flush, e_redir, e_class);
			check_bit("br_taken_o", br_taken_o, e_taken);
			check_bit("flush_o", flush_o, e_flush);
			check_word("redirect_pc_o", redirect_pc_o, e_redir);
			check_class("br_class_o", br_class_o, e_class);
			check_word("pc_link_o", pc_link_o, res_pc_i + 32'd4);
		end
	end

	initial begin
		#(N_CYCLES * 10 * 8 + 1000);
		fail_run("timeout: the test sequence did not finish in time");
	end

	task automatic apply_reset();
		@(posedge clk);
		#1 arst_n_i = 1'b0;
		res_valid_i = 1'b0;
		repeat (2) @(posedge clk);
		#1 arst_n_i = 1'b1;
	endtask

	task automatic resolve(input logic [31:0] pc, input logic [31:0] rj, input logic [31:0] rd,
			input logic [25:0] inst, input logic [1:0] btype, input logic [2:0] ctype,
			input logic link, input logic ptaken, input logic [29:0] pnpc);
		@(posedge clk);
		#1;
		res_valid_i      = 1'b1;
		res_pc_i         = pc;
		rj_val_i         = rj;
		rd_val_i         = rd;
		inst_bits        = inst;
		branch_type_i    = btype;
		cmp_type_i       = ctype;
		branch_link_i    = link;
		res_pred_taken_i = ptaken;
		res_pred_npc_i   = pnpc;
	endtask

	task automatic lookup(input logic [31:0] pc, input logic exp_taken, input logic [29:0] exp_npc);
		@(posedge clk);
		#1;
		res_valid_i = 1'b0;
		fetch_pc_i  = pc;
		@(negedge clk);
		check_bit("pred_taken_o", pred_taken_o, exp_taken);
		check_word("pred_npc_o", {2'b00, pred_npc_o}, {2'b00, exp_npc});
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		logic [31:0] r;
		logic [31:0] b;
		logic [31:0] rj;
		logic [31:0] rd;
		logic [31:0] pc;
		logic [31:0] inst;
		logic [31:0] c;
		lfsr_q = 32'h1e17;
		err_cnt = 0;
		arst_n_i = 1'b0;
		fetch_pc_i = '0;
		res_valid_i = 1'b0;
		stall_i = 1'b0;
		csr_flush_i = 1'b0;
		csr_target_i = '0;
		res_pc_i = '0;
		rj_val_i = '0;
		rd_val_i = '0;
		inst_bits = '0;
		branch_type_i = bpu_pkg::INVALID;
		cmp_type_i = bpu_pkg::EQL;
		branch_link_i = 1'b0;
		res_pred_taken_i = 1'b0;
		res_pred_npc_i = '0;
		repeat (2) @(posedge clk);
		#1 arst_n_i = 1'b1;

		// Random conditional branches, predicted not taken
		for (int i = 0; i < 200; i++) begin
			r = next_bits(30);
			rj = next_bits(32);
			b = next_bits(1);
			rd = next_bits(32);
			if (b[0])
				rd = rj;
			c = next_bits(3);
			inst = next_bits(26);
			resolve({r[29:0], 2'b00}, rj, rd, inst[25:0], bpu_pkg::CONDITION, c[2:0], 1'b0,
				1'b0, '0);
		end

		// Jumps with call, return and absolute classes
		for (int i = 0; i < 60; i++) begin
			r = next_bits(30);
			rj = next_bits(32);
			inst = next_bits(26);
			c = next_bits(2);
			b = next_bits(2);
			if (c[1:0] == 2'd0)
				inst[25:5] = {16'h0, 5'd1};
			if (c[1:0] == 2'd2)
				inst[4:0] = 5'd1;
			resolve({r[29:0], 2'b00}, rj, '0, inst[25:0],
				b[0] ? bpu_pkg::INDIRECT : bpu_pkg::IMMEDIATE, bpu_pkg::EQL, b[1], 1'b0, '0);
		end

		// Correct prediction, stall mask and pc+4 repair
		resolve(32'h500, '0, '0, {16'h0020, 10'd0}, bpu_pkg::IMMEDIATE, bpu_pkg::EQL, 1'b0,
			1'b1, 30'(32'h580 >> 2));
		@(negedge clk);
		check_bit("flush_o", flush_o, 1'b0);
		resolve(32'h540, '0, '0, {16'h0020, 10'd0}, bpu_pkg::IMMEDIATE, bpu_pkg::EQL, 1'b0,
			1'b0, '0);
		stall_i = 1'b1;
		@(negedge clk);
		check_bit("flush_o", flush_o, 1'b0);
		resolve(32'h600, 32'd1, 32'd2, {16'h0040, 10'd0}, bpu_pkg::CONDITION, bpu_pkg::EQL,
			1'b0, 1'b1, 30'(32'h700 >> 2));
		stall_i = 1'b0;
		@(negedge clk);
		check_word("redirect_pc_o", redirect_pc_o, 32'h604);

		// Predictor training
		apply_reset();
		lookup(32'h1230, 1'b0, 30'(32'h1238 >> 2));
		resolve(32'h1230, '0, '0, {16'h0040, 10'd0}, bpu_pkg::IMMEDIATE, bpu_pkg::EQL, 1'b0,
			1'b0, '0);
		lookup(32'h1230, 1'b1, 30'((32'h1230 + 32'h100) >> 2));
		resolve(32'h2044, 32'd5, 32'd5, {16'h0008, 10'd0}, bpu_pkg::CONDITION, bpu_pkg::EQL,
			1'b0, 1'b0, '0);
		lookup(32'h2044, 1'b1, 30'((32'h2044 + 32'h20) >> 2));
		repeat (2)
			resolve(32'h2044, 32'd5, 32'd6, {16'h0008, 10'd0}, bpu_pkg::CONDITION,
				bpu_pkg::EQL, 1'b0, 1'b0, '0);
		lookup(32'h2044, 1'b0, 30'(32'h2048 >> 2));

		// Call, return, call again, then the return predicts from the stack
		apply_reset();
		resolve(32'h1000, '0, '0, {16'h0010, 10'd0}, bpu_pkg::IMMEDIATE, bpu_pkg::EQL, 1'b1,
			1'b0, '0);
		resolve(32'h2010, 32'h1004, '0, {16'h0, 5'd1, 5'd0}, bpu_pkg::INDIRECT, bpu_pkg::EQL,
			1'b0, 1'b0, '0);
		resolve(32'h3020, '0, '0, {16'h0010, 10'd0}, bpu_pkg::IMMEDIATE, bpu_pkg::EQL, 1'b1,
			1'b0, '0);
		lookup(32'h2010, 1'b1, 30'((32'h3020 + 32'd4) >> 2));

		// CSR redirect wins over everything
		for (int i = 0; i < 20; i++) begin
			r = next_bits(32);
			rj = next_bits(32);
			rd = next_bits(32);
			inst = next_bits(26);
			c = next_bits(8);
			resolve(rd ^ rj, rj, rd, inst[25:0], c[1:0], c[4:2], c[5], c[6], rj[29:0]);
			csr_flush_i = 1'b1;
			csr_target_i = r;
			res_valid_i = c[7];
			stall_i = c[0];
			@(negedge clk);
			check_bit("flush_o", flush_o, 1'b1);
			check_word("redirect_pc_o", redirect_pc_o, r);
		end
		@(posedge clk);
		#1;
		csr_flush_i = 1'b0;
		stall_i = 1'b0;
		res_valid_i = 1'b0;
		@(negedge clk);

		if (err_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- compile.f
bpu_pkg.sv
bpu_btb.sv
bpu_bht.sv
bpu_ras.sv
bpu_predictor.sv
bpf.sv
bpu_top.sv
tb_bpu.sv

//--- Makefile
RTL = bpu_pkg.sv bpu_btb.sv bpu_bht.sv bpu_ras.sv bpu_predictor.sv bpf.sv bpu_top.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -f compile.f --top-module tb_bpu -o Vtb_bpu

run: build
	./obj_dir/Vtb_bpu | tee /dev/stderr | grep -q "^Done: no errors$$"

lint:
	verilator --lint-only -Wall --top-module bpu_top $(RTL)

clean:
	rm -rf obj_dir
